// ==== hdl/binFifo.sv ====
module binFifo (
    input  logic                          clk,
    input  logic                          res,
    input  logic                          push,
    input  logic [sifhPkg::binWidth-1:0]  pushAddr,
    input  logic                          pop,
    output logic                          notEmpty,
    output logic [sifhPkg::binWidth-1:0]  headAddr,
    output logic [sifhPkg::dropWidth-1:0] droppedCount
);
    import sifhPkg::*;

    logic [binWidth-1:0]     mem [fifoDepth];
    logic [fifoPtrWidth-1:0] wrPtr;
    logic [fifoPtrWidth-1:0] rdPtr;
    logic [fifoCntWidth-1:0] occupancy;
    logic                    full;
    logic                    doPush;
    logic                    doPop;

    assign full     = (occupancy == fifoCntWidth'(fifoDepth));
    assign notEmpty = (occupancy != '0);
    assign doPush   = push && !full;
    assign doPop    = pop && notEmpty;
    assign headAddr = mem[rdPtr];  // oldest entry, shown without a pop

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            wrPtr        <= '0;
            rdPtr        <= '0;
            occupancy    <= '0;
            droppedCount <= '0;
        end else begin
            // pointers wrap on their own, depth is a power of two
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end

            case ({doPush, doPop})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;  // idle, or push and pop together
            endcase

            // photon lost to a full buffer
            if (push && full && droppedCount != dropMax) begin
                droppedCount <= droppedCount + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushAddr;
        end
    end

endmodule

// ==== hdl/histogramBuilder.sv ====
module histogramBuilder (
    input  logic                           clk,
    input  logic                           res,
    input  logic                           frameStart,
    input  logic                           notEmpty,
    input  logic [sifhPkg::binWidth-1:0]   headAddr,
    output logic                           pop,
    output logic                           acquiring,
    output logic                           countStrobe,
    output logic [sifhPkg::binWidth-1:0]   countBin,
    output logic [sifhPkg::countWidth-1:0] binCount,
    output logic                           frameDone
);
    import sifhPkg::*;

    logic [stateWidth-1:0]  state;
    logic [acqCntWidth-1:0] acqCnt;     // window length, reused for the drain settle
    logic [binWidth-1:0]    readIdx;
    logic [numBins-1:0]     validBits;  // bin written in this frame
    logic [countWidth-1:0]  mem [numBins];

    // increment pipeline, read stage result
    logic                   rdValid;
    logic                   rdHit;
    logic [binWidth-1:0]    rdBin;
    logic [countWidth-1:0]  rdData;
    logic [countWidth-1:0]  newCount;

    logic                   windowEnd;
    logic                   settled;
    logic                   drainDone;

    assign acquiring = (state == stAcquire);

    // the write stage owns the port, so no pop while it is busy
    assign pop = notEmpty && !rdValid && (state == stAcquire || state == stDrain);

    assign windowEnd = (acqCnt == acqCntWidth'(acqCycles - 1));
    assign settled   = (acqCnt >= acqCntWidth'(drainSettle));
    assign drainDone = settled && !notEmpty && !rdValid;

    // stale words from an earlier frame count as zero
    always_comb begin
        if (!rdHit) begin
            newCount = countWidth'(1);
        end else if (rdData == countMax) begin
            newCount = countMax;  // hold once saturated
        end else begin
            newCount = rdData + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state       <= stIdle;
            acqCnt      <= '0;
            readIdx     <= '0;
            validBits   <= '0;
            rdValid     <= 1'b0;
            rdHit       <= 1'b0;
            countStrobe <= 1'b0;
            frameDone   <= 1'b0;
        end else begin
            rdValid <= pop;
            if (pop) begin
                rdHit <= validBits[headAddr];
            end
            if (rdValid) begin
                validBits[rdBin] <= 1'b1;
            end

            // readout stream trails the memory read by one cycle
            countStrobe <= (state == stReadout);
            frameDone   <= countStrobe && (countBin == binWidth'(numBins - 1));

            case (state)
                stIdle: begin
                    if (frameStart) begin
                        validBits <= '0;  // whole histogram cleared at once
                        acqCnt    <= '0;
                        state     <= stAcquire;
                    end
                end
                stAcquire: begin
                    if (windowEnd) begin
                        acqCnt <= '0;
                        state  <= stDrain;
                    end else begin
                        acqCnt <= acqCnt + 1'b1;
                    end
                end
                stDrain: begin
                    // wait for photons still in the binner, then for the backlog
                    if (drainDone) begin
                        readIdx <= '0;
                        state   <= stReadout;
                    end else if (!settled) begin
                        acqCnt <= acqCnt + 1'b1;
                    end
                end
                stReadout: begin
                    readIdx <= readIdx + 1'b1;
                    if (readIdx == binWidth'(numBins - 1)) begin
                        state <= stIdle;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    // single memory port shared by increment read, increment write and readout
    always_ff @(posedge clk) begin
        if (rdValid) begin
            mem[rdBin] <= newCount;
        end else if (pop) begin
            rdData <= mem[headAddr];
            rdBin  <= headAddr;
        end else if (state == stReadout) begin
            binCount <= validBits[readIdx] ? mem[readIdx] : '0;
            countBin <= readIdx;
        end
    end

endmodule

// ==== hdl/photonBinner.sv ====
module photonBinner (
    input  logic                         clk,
    input  logic                         res,
    input  logic                         photonStrobe,
    input  logic [sifhPkg::tsWidth-1:0]  timestamp,
    input  logic                         coarseMode,
    input  logic                         acquiring,
    output logic                         binStrobe,
    output logic [sifhPkg::binWidth-1:0] binAddr
);
    import sifhPkg::*;

    logic [tsWidth-1:0]  shifted;
    logic [binWidth-1:0] nextAddr;
    logic                inRange;
    logic                accept;

    assign shifted = timestamp >> coarseShift;

    // fine mode keeps the low range only, coarse mode divides down
    always_comb begin
        if (coarseMode) begin
            nextAddr = shifted[binWidth-1:0];
            inRange  = 1'b1;  // every timestamp has a bin
        end else begin
            nextAddr = timestamp[binWidth-1:0];
            inRange  = (timestamp < tsWidth'(numBins));
        end
    end

    // photons outside the window never reach the FIFO
    assign accept = photonStrobe && acquiring && inRange;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            binStrobe <= 1'b0;
        end else begin
            binStrobe <= accept;  // one cycle after the photon
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            binAddr <= nextAddr;
        end
    end

endmodule

// ==== hdl/sifhPkg.sv ====
package sifhPkg;

    // photon timestamp and bin addressing
    localparam int tsWidth     = 10;
    localparam int binWidth    = 5;
    localparam int numBins     = 32;
    localparam int coarseShift = 5;  // 1024 timestamps onto 32 bins

    // per-bin counters, saturating
    localparam int countWidth = 8;
    localparam logic [countWidth-1:0] countMax = '1;

    // burst buffer between binner and builder
    localparam int fifoDepth    = 8;
    localparam int fifoPtrWidth = $clog2(fifoDepth);
    localparam int fifoCntWidth = $clog2(fifoDepth + 1);  // holds 0..fifoDepth

    // lost photons, saturating
    localparam int dropWidth = 16;
    localparam logic [dropWidth-1:0] dropMax = '1;

    // acquisition window
    localparam int acqCycles   = 1024;
    localparam int acqCntWidth = $clog2(acqCycles);

    // a photon seen in the last window cycle needs this long to reach the FIFO head
    localparam int drainSettle = 2;

    // builder FSM encoding
    localparam int stateWidth = 2;
    localparam logic [stateWidth-1:0] stIdle    = 2'd0;
    localparam logic [stateWidth-1:0] stAcquire = 2'd1;
    localparam logic [stateWidth-1:0] stDrain   = 2'd2;
    localparam logic [stateWidth-1:0] stReadout = 2'd3;

endpackage

// ==== hdl/sifhTop.sv ====
module sifhTop (
    input  logic                           clk,
    input  logic                           res,
    input  logic                           photonStrobe,
    input  logic [sifhPkg::tsWidth-1:0]    timestamp,
    input  logic                           coarseMode,
    input  logic                           frameStart,
    output logic                           acquiring,
    output logic                           countStrobe,
    output logic [sifhPkg::binWidth-1:0]   countBin,
    output logic [sifhPkg::countWidth-1:0] binCount,
    output logic                           frameDone,
    output logic [sifhPkg::dropWidth-1:0]  droppedCount
);
    import sifhPkg::*;

    logic                binStrobe;
    logic [binWidth-1:0] binAddr;
    logic                notEmpty;
    logic [binWidth-1:0] headAddr;
    logic                pop;

    photonBinner u_binner (
        .clk          (clk),
        .res          (res),
        .photonStrobe (photonStrobe),
        .timestamp    (timestamp),
        .coarseMode   (coarseMode),
        .acquiring    (acquiring),
        .binStrobe    (binStrobe),
        .binAddr      (binAddr)
    );

    binFifo u_fifo (
        .clk          (clk),
        .res          (res),
        .push         (binStrobe),
        .pushAddr     (binAddr),
        .pop          (pop),
        .notEmpty     (notEmpty),
        .headAddr     (headAddr),
        .droppedCount (droppedCount)
    );

    histogramBuilder u_builder (
        .clk         (clk),
        .res         (res),
        .frameStart  (frameStart),
        .notEmpty    (notEmpty),
        .headAddr    (headAddr),
        .pop         (pop),
        .acquiring   (acquiring),
        .countStrobe (countStrobe),
        .countBin    (countBin),
        .binCount    (binCount),
        .frameDone   (frameDone)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the histogram subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module sifhTb -o sifhSim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

if [ ! -x ./obj_dir/sifhSim ]; then
    echo "simulation binary not found"
    exit 1
fi

output=$(./obj_dir/sifhSim)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
    echo "RESULT: PASS"
    exit 0
fi

echo "RESULT: FAIL"
exit 1

// ==== verification/sifhTb.sv ====
module sifhTb;
    import sifhPkg::*;

    localparam int numRows      = 6;
    localparam int clkPeriod    = 8;
    localparam int watchdogTime = numRows * (acqCycles + numBins + 64) * clkPeriod;
    localparam int readoutWait  = acqCycles + numBins + 64;
    localparam int countLimit   = (1 << countWidth) - 1;
    localparam int binSpan      = 1 << coarseShift;  // timestamps per coarse bin

    // photon patterns
    localparam int patFixed  = 0;
    localparam int patStep   = 1;  // timestamp = index * value
    localparam int patRandom = 2;

    // one row per frame
    string rowName [numRows] = '{
        "fineStep", "coarseRandom", "saturate", "lazyClear", "coarseStep", "overflow"
    };
    bit rowCoarse   [numRows] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0};
    int rowPhotons  [numRows] = '{64, 200, 300, 12, 48, 40};
    int rowPattern  [numRows] = '{patStep, patRandom, patFixed, patFixed, patStep, patFixed};
    int rowValue    [numRows] = '{1, 0, 7, 20, 21, 5};   // fixed timestamp or step
    int rowSpacing  [numRows] = '{2, 2, 3, 4, 2, 1};
    bit rowOverflow [numRows] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

    logic                  clk = 1'b0;
    logic                  res;
    logic                  photonStrobe;
    logic [tsWidth-1:0]    timestamp;
    logic                  coarseMode;
    logic                  frameStart;
    logic                  acquiring;
    logic                  countStrobe;
    logic [binWidth-1:0]   countBin;
    logic [countWidth-1:0] binCount;
    logic                  frameDone;
    logic [dropWidth-1:0]  droppedCount;

    int          errorCount = 0;
    int          refHist [numBins];
    logic [31:0] rngState;

    always #(clkPeriod / 2) clk = ~clk;

    sifhTop u_dut (
        .clk          (clk),
        .res          (res),
        .photonStrobe (photonStrobe),
        .timestamp    (timestamp),
        .coarseMode   (coarseMode),
        .frameStart   (frameStart),
        .acquiring    (acquiring),
        .countStrobe  (countStrobe),
        .countBin     (countBin),
        .binCount     (binCount),
        .frameDone    (frameDone),
        .droppedCount (droppedCount)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stepCycle;
        @(posedge clk);
        #1;  // outputs settled, inputs change away from the edge
    endtask

    task automatic reportError(input string msg);
        errorCount++;
        $display("ERROR: %s", msg);
    endtask

    task automatic checkCount(input string what, input logic [countWidth-1:0] expected,
                              input logic [countWidth-1:0] actual);
        if (actual !== expected) begin
            errorCount++;
            $display("MISMATCH %s: expected %0d, actual %0d", what, expected, actual);
        end
    endtask

    task automatic checkBin(input string what, input logic [binWidth-1:0] expected,
                            input logic [binWidth-1:0] actual);
        if (actual !== expected) begin
            errorCount++;
            $display("MISMATCH %s: expected %0d, actual %0d", what, expected, actual);
        end
    endtask

    task automatic checkDrop(input string what, input logic [dropWidth-1:0] expected,
                             input logic [dropWidth-1:0] actual);
        if (actual !== expected) begin
            errorCount++;
            $display("MISMATCH %s: expected %0d, actual %0d", what, expected, actual);
        end
    endtask

    task automatic nextTimestamp(input int row, input int idx, output int ts);
        case (rowPattern[row])
            patFixed: ts = rowValue[row];
            patStep:  ts = (idx * rowValue[row]) % (1 << tsWidth);
            default: begin
                rngState = xorshift(rngState);
                ts = int'(rngState[tsWidth-1:0]);
            end
        endcase
    endtask

    // binning rule, fine mode keeps only the low range
    task automatic addReference(input bit coarse, input int ts);
        int bin;
        bin = -1;
        if (coarse) begin
            bin = ts / binSpan;
        end else if (ts < numBins) begin
            bin = ts;
        end
        if (bin >= 0 && refHist[bin] < countLimit) begin
            refHist[bin]++;
        end
    endtask

    task automatic runFrame(input int row);
        int ts;
        int waited;
        int strobes;
        int sum;
        logic [dropWidth-1:0] dropBefore;
        logic [dropWidth-1:0] dropDelta;
        for (int k = 0; k < numBins; k++) begin
            refHist[k] = 0;
        end
        dropBefore = droppedCount;
        coarseMode = rowCoarse[row];

        frameStart = 1'b1;
        stepCycle();
        frameStart = 1'b0;
        waited = 0;
        while (!acquiring && waited < 4) begin
            stepCycle();
            waited++;
        end
        if (!acquiring) begin
            reportError($sformatf("%s: acquiring never rose after frameStart", rowName[row]));
        end

        for (int i = 0; i < rowPhotons[row]; i++) begin
            nextTimestamp(row, i, ts);
            if (!acquiring) begin
                reportError($sformatf("%s: photon %0d fell outside the window", rowName[row], i));
            end
            photonStrobe = 1'b1;
            timestamp    = tsWidth'(ts);
            addReference(rowCoarse[row], ts);
            stepCycle();
            photonStrobe = 1'b0;
            repeat (rowSpacing[row] - 1) stepCycle();
        end

        waited = 0;
        while (!countStrobe && waited < readoutWait) begin
            stepCycle();
            waited++;
        end
        if (!countStrobe) begin
            reportError($sformatf("%s: no readout stream appeared", rowName[row]));
        end

        strobes = 0;
        sum     = 0;
        while (countStrobe) begin
            if (strobes < numBins) begin
                checkBin($sformatf("%s strobe %0d", rowName[row], strobes),
                         binWidth'(strobes), countBin);
                if (!rowOverflow[row] || refHist[strobes] == 0) begin
                    checkCount($sformatf("%s bin %0d", rowName[row], strobes),
                               countWidth'(refHist[strobes]), binCount);
                end
                sum += int'(binCount);
            end
            strobes++;
            stepCycle();
        end
        if (strobes != numBins) begin
            reportError($sformatf("%s: readout gave %0d strobes instead of %0d",
                                  rowName[row], strobes, numBins));
        end
        if (frameDone !== 1'b1) begin
            reportError($sformatf("%s: frameDone missing after the last bin", rowName[row]));
        end
        stepCycle();
        if (frameDone !== 1'b0) begin
            reportError($sformatf("%s: frameDone stayed high too long", rowName[row]));
        end

        dropDelta = droppedCount - dropBefore;
        if (rowOverflow[row]) begin
            // every photon is either counted or dropped
            checkDrop($sformatf("%s drops", rowName[row]),
                      dropWidth'(rowPhotons[row] - sum), dropDelta);
            if (dropDelta == '0) begin
                reportError($sformatf("%s: burst lost no photons to the full FIFO",
                                      rowName[row]));
            end
        end else begin
            checkDrop($sformatf("%s drops", rowName[row]), '0, dropDelta);
        end
    endtask

    initial begin
        res          = 1'b0;
        photonStrobe = 1'b0;
        timestamp    = '0;
        coarseMode   = 1'b0;
        frameStart   = 1'b0;
        rngState     = 32'd4;
        repeat (2) @(posedge clk);
        #1;
        res = 1'b1;
        stepCycle();
        checkDrop("reset drops", '0, droppedCount);
        if (acquiring || countStrobe || frameDone) begin
            reportError("outputs not idle after reset");
        end

        for (int row = 0; row < numRows; row++) begin
            runFrame(row);
        end

        $display("errors: %0d", errorCount);
        if (errorCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(watchdogTime);
        $display("watchdog expired before all frames finished, errors so far: %0d", errorCount);
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== verilog.f ====
hdl/sifhPkg.sv
hdl/photonBinner.sv
hdl/binFifo.sv
hdl/histogramBuilder.sv
hdl/sifhTop.sv
verification/sifhTb.sv
